//--- cpu_cfg_pkg.sv
package cpu_cfg_pkg;

  localparam int data_w = 16;

  localparam int dstk_depth = 16;                // Below the two top registers
  localparam int dstk_aw    = $clog2(dstk_depth);
  localparam int dstk_cw    = $clog2(dstk_depth + 3);
  localparam int cstk_depth = 16;
  localparam int cstk_aw    = $clog2(cstk_depth);
  localparam int cstk_cw    = cstk_aw + 1;

  localparam logic [data_w-1:0] reset_ip = '0;

endpackage

//--- cpu_isa_pkg.sv
package cpu_isa_pkg;

  localparam int insn_w = 16;

  localparam logic [insn_w-1:0] insn_isr_load = 16'h7811;

  // Immediate field masks per instruction class
  localparam logic [insn_w-1:0] imm_mask_lit  = 16'h7fff;  // PUSH literal
  localparam logic [insn_w-1:0] imm_mask_br   = 16'h0ffe;  // JMP, CALL, JZ, JNZ
  localparam logic [insn_w-1:0] imm_mask_word = 16'h03fe;  // LD, ST
  localparam logic [insn_w-1:0] imm_mask_byte = 16'h03ff;

  typedef enum logic [1:0] {
    src_stk0 = 2'h0,
    src_fp   = 2'h1,
    src_ip   = 2'h2,
    src_cstk = 2'h3
  } src_a_t;

  typedef enum logic [1:0] {
    src_imm  = 2'h0,
    src_stk1 = 2'h1,
    src_isr  = 2'h2
  } src_b_t;

  typedef enum logic [5:0] {
    alu_add   = 6'd0,
    alu_sub   = 6'd1,
    alu_and   = 6'd2,
    alu_or    = 6'd3,
    alu_xor   = 6'd4,
    alu_shl   = 6'd5,
    alu_shr   = 6'd6,
    alu_eq    = 6'd7,
    alu_lt    = 6'd8,
    alu_not   = 6'd9,
    alu_a     = 6'd10,
    alu_b     = 6'd11,
    alu_addz  = 6'd12,
    alu_addnz = 6'd13
  } alu_sel_t;

endpackage

//--- cpu_ifs.sv
`timescale 1ns/100ps

interface decode_if;
  import cpu_isa_pkg::*;

  logic              sign;
  logic [insn_w-1:0] imm_mask;
  src_a_t            src_a;
  src_b_t            src_b;
  alu_sel_t          alu_sel;
  logic              wr_stk1, pop, push, load_stk, load_fp, load_ip, load_isr;
  logic              cpop, cpush, byt, rd_mem, wr_mem;

  modport dec (output sign, imm_mask, src_a, src_b, alu_sel, wr_stk1, pop, push, load_stk,
               load_fp, load_ip, load_isr, cpop, cpush, byt, rd_mem, wr_mem);
  modport exe (input sign, imm_mask, src_a, src_b, alu_sel, wr_stk1, pop, push, load_stk,
               load_fp, load_ip, load_isr, cpop, cpush, byt, rd_mem, wr_mem);
endinterface

interface stack_if;
  import cpu_cfg_pkg::*;

  logic              push, pop, load, wr_stk1;
  logic [data_w-1:0] din;
  logic [data_w-1:0] stk0, stk1;

  modport user (output push, pop, load, wr_stk1, din, input stk0, stk1);
  modport stk (input push, pop, load, wr_stk1, din, output stk0, stk1);
endinterface

interface cstk_if;
  import cpu_cfg_pkg::*;

  logic              cpush, cpop;
  logic [data_w-1:0] cdin, ctop;

  modport user (output cpush, cpop, cdin, input ctop);
  modport stk (input cpush, cpop, cdin, output ctop);
endinterface

//--- decoder.sv
`timescale 1ns/100ps

module decoder (
  input logic [cpu_isa_pkg::insn_w-1:0] insn,
  decode_if.dec                         dec
);
  import cpu_isa_pkg::*;

  function automatic logic calc_sign(input logic [insn_w-1:0] i);
    priority casez (i)
      16'b000?_????_????_????: return i[11];
      16'b001?_????_????_????: return i[9];
      16'b010?_????_????_????: return i[9];
      default:                 return 1'b0;
    endcase
  endfunction

  function automatic logic [insn_w-1:0] calc_imm_mask(input logic [3:0] op);
    priority casez (op)
      4'b1???: return imm_mask_lit;
      4'b000?: return imm_mask_br;
      4'b0100: return imm_mask_word;
      default: return imm_mask_byte;
    endcase
  endfunction

  function automatic src_a_t calc_src_a(input logic [insn_w-1:0] i);
    priority casez (i)
      16'b000?_????_????_????: return src_ip;              // Branches
      16'b001?_????_????_????: return src_a_t'(i[11:10]);  // LD.1, ST.1
      16'b010?_????_????_????: return src_a_t'(i[11:10]);  // LD, ST, PUSH
      16'b0110_01??_????_????: return src_fp;              // ADD FP
      16'b0111_1???_???1_???0: return src_ip;              // INT
      16'b0111_1???_????_00?0: return src_cstk;            // RET, CPOP FP
      16'b0111_1???_????_0011: return src_fp;              // CPUSH FP
      default:                 return src_stk0;
    endcase
  endfunction

  function automatic src_b_t calc_src_b(input logic [insn_w-1:0] i);
    priority casez (i)
      16'b0111_1???_???1_????: return src_isr;
      16'b0111_????_????_????: return src_stk1;
      default:                 return src_imm;
    endcase
  endfunction

  function automatic alu_sel_t calc_alu_sel(input logic [insn_w-1:0] i);
    priority casez (i)
      16'b1???_????_????_????: return alu_b;               // PUSH literal
      16'b0001_????_????_???0: return alu_addz;            // JZ
      16'b0001_????_????_???1: return alu_addnz;           // JNZ
      16'b001?_00??_????_????: return alu_b;               // Direct byte access
      16'b010?_00??_????_????: return alu_b;               // Direct word access
      16'b0110_00??_????_????: return alu_b;               // ICALL
      16'b0111_0???_????_????: return alu_sel_t'(i[5:0]);
      16'b0111_1???_???1_???0: return alu_b;               // INT
      16'b0111_1???_????_????: return alu_a;
      default:                 return alu_add;
    endcase
  endfunction

  function automatic logic calc_push(input logic [insn_w-1:0] i);
    priority casez (i)
      16'b1???_????_????_????: return 1'b1;
      16'b0010_????_????_????: return 1'b1;
      16'b0100_????_????_???0: return 1'b1;
      16'b0101_????_????_????: return 1'b1;
      16'b0111_????_1???_????: return 1'b1;                // Push flag
      default:                 return 1'b0;
    endcase
  endfunction

  function automatic logic calc_pop(input logic [insn_w-1:0] i);
    priority casez (i)
      16'b0001_????_????_????: return 1'b1;
      16'b0011_????_????_????: return 1'b1;
      16'b0100_????_????_???1: return 1'b1;
      16'b0111_0???_?1??_????: return 1'b1;                // Pop flag
      16'b0111_1???_????_?1??: return 1'b1;
      16'b0111_1???_???1_???1: return 1'b1;                // ISR load
      default:                 return 1'b0;
    endcase
  endfunction

  assign dec.sign     = calc_sign(insn);
  assign dec.imm_mask = calc_imm_mask(insn[15:12]);
  assign dec.src_a    = calc_src_a(insn);
  assign dec.src_b    = calc_src_b(insn);
  assign dec.alu_sel  = calc_alu_sel(insn);
  assign dec.wr_stk1  = (calc_src_b(insn) == src_stk1) && insn[3];
  assign dec.push     = calc_push(insn);
  assign dec.pop      = calc_pop(insn);
  assign dec.load_stk = calc_push(insn) || insn[15:11] == 5'b0111_0 ||
                        (insn[15:11] == 5'b0111_1 && insn[3] && !insn[1]);
  assign dec.load_fp  = insn[15:10] == 6'b0110_01 ||
                        (insn[15:11] == 5'b0111_1 && insn[3:0] == 4'b0010);
  assign dec.load_ip  = insn[15:13] == 3'b000 || insn[15:10] == 6'b0110_00 ||
                        (insn[15:11] == 5'b0111_1 && insn[3:0] == 4'b0000);
  assign dec.load_isr = insn == insn_isr_load;
  assign dec.cpop     = insn[15:11] == 5'b0111_1 && !insn[4] && insn[3:2] == 2'b00 && !insn[0];
  assign dec.cpush    = (insn[15:12] == 4'b0000 && insn[0]) || insn[15:10] == 6'b0110_00 ||
                        (insn[15:11] == 5'b0111_1 && insn[4] && !insn[0]) ||
                        (insn[15:11] == 5'b0111_1 && insn[3:0] == 4'b0011);
  assign dec.byt      = insn[15:13] == 3'b001 || (insn[15:12] == 4'b0111 && insn[0]);
  assign dec.rd_mem   = insn[15:12] == 4'b0010 || (insn[15:12] == 4'b0100 && !insn[0]) ||
                        insn[15:10] == 6'b0110_00 ||
                        (insn[15:11] == 5'b0111_1 && insn[3:2] == 2'b10);
  assign dec.wr_mem   = insn[15:12] == 4'b0011 || (insn[15:12] == 4'b0100 && insn[0]) ||
                        (insn[15:11] == 5'b0111_1 && insn[3:2] == 2'b11);

endmodule

//--- alu.sv
`timescale 1ns/100ps

module alu (
  input  cpu_isa_pkg::alu_sel_t             sel,
  input  logic [cpu_cfg_pkg::data_w-1:0] a,
  input  logic [cpu_cfg_pkg::data_w-1:0] b,
  input  logic [cpu_cfg_pkg::data_w-1:0] stk0,
  output logic [cpu_cfg_pkg::data_w-1:0] result
);
  import cpu_cfg_pkg::*;
  import cpu_isa_pkg::*;

  logic [data_w-1:0] sum;
  logic [data_w-1:0] step;

  assign sum  = a + b;
  assign step = a + data_w'(2);  // Fall-through address

  always_comb
  begin
    case (sel)
      alu_add:   result = sum;
      alu_sub:   result = a - b;
      alu_and:   result = a & b;
      alu_or:    result = a | b;
      alu_xor:   result = a ^ b;
      alu_shl:   result = a << b[$clog2(data_w)-1:0];
      alu_shr:   result = a >> b[$clog2(data_w)-1:0];
      alu_eq:    result = data_w'(a == b);
      alu_lt:    result = data_w'($signed(a) < $signed(b));  // Signed compare
      alu_not:   result = ~a;
      alu_a:     result = a;
      alu_b:     result = b;
      alu_addz:  result = (stk0 == '0) ? sum : step;
      alu_addnz: result = (stk0 != '0) ? sum : step;
      default:   result = '0;
    endcase
  end

endmodule

//--- data_stack.sv
`timescale 1ns/100ps

module data_stack (
  input logic  clk,
  input logic  rst_n,
  stack_if.stk s
);
  import cpu_cfg_pkg::*;

  logic [data_w-1:0]  mem [dstk_depth];
  logic [data_w-1:0]  top0, top1;
  logic [dstk_cw-1:0] depth;    // Live entries including the two registers
  logic [dstk_cw-1:0] mem_cnt;
  logic [dstk_aw-1:0] sp;

  assign mem_cnt = depth - dstk_cw'(2);
  assign sp      = mem_cnt[dstk_aw-1:0];
  assign s.stk0  = top0;
  assign s.stk1  = top1;

  always_ff @(posedge clk)
  begin
    if (s.push && !s.pop && depth >= dstk_cw'(2))
      mem[sp] <= top1;  // Spill below the registers
    if (s.push && !s.pop)
      top1 <= top0;
    else if (s.pop && !s.push)
    begin
      top0 <= top1;
      top1 <= mem[sp - dstk_aw'(1)];
    end
    if (s.load)
    begin
      if (s.wr_stk1)
        top1 <= s.din;
      else
        top0 <= s.din;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      depth <= '0;
    else if (s.push && !s.pop)
      depth <= depth + dstk_cw'(1);
    else if (s.pop && !s.push)
      depth <= depth - dstk_cw'(1);
  end

  a_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    s.pop |-> depth != '0) else $error("data stack underflow");
  a_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (s.push && !s.pop) |-> depth != dstk_cw'(dstk_depth + 2)) else $error("data stack overflow");

endmodule

//--- call_stack.sv
`timescale 1ns/100ps

module call_stack (
  input logic clk,
  input logic rst_n,
  cstk_if.stk c
);
  import cpu_cfg_pkg::*;

  logic [data_w-1:0]  mem [cstk_depth];
  logic [cstk_cw-1:0] ptr;      // Entries in use
  logic [cstk_aw-1:0] top_idx;

  assign top_idx = ptr[cstk_aw-1:0] - cstk_aw'(1);
  assign c.ctop  = mem[top_idx];

  always_ff @(posedge clk)
  begin
    if (c.cpush)
      mem[ptr[cstk_aw-1:0]] <= c.cdin;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      ptr <= '0;
    else if (c.cpush && !c.cpop)
      ptr <= ptr + cstk_cw'(1);
    else if (c.cpop && !c.cpush)
      ptr <= ptr - cstk_cw'(1);
  end

  a_cunderflow: assert property (@(posedge clk) disable iff (!rst_n)
    c.cpop |-> ptr != '0) else $error("call stack underflow");
  a_coverflow: assert property (@(posedge clk) disable iff (!rst_n)
    c.cpush |-> ptr != cstk_cw'(cstk_depth)) else $error("call stack overflow");

endmodule

//--- stack_cpu.sv
`timescale 1ns/100ps

module stack_cpu (
  input  logic                              clk,
  input  logic                              rst_n,
  output logic [cpu_cfg_pkg::data_w-1:0]   imem_addr,
  input  logic [cpu_isa_pkg::insn_w-1:0]   insn,
  output logic [cpu_cfg_pkg::data_w-1:0]   dmem_addr,
  output logic [cpu_cfg_pkg::data_w-1:0]   dmem_wdata,
  output logic                              dmem_we,
  output logic                              dmem_re,
  output logic                              dmem_byte,
  input  logic [cpu_cfg_pkg::data_w-1:0]   dmem_rdata
);
  import cpu_cfg_pkg::*;
  import cpu_isa_pkg::*;

  logic [data_w-1:0] ip, fp, isr, ip_next2;
  logic [data_w-1:0] op_a, op_b, alu_res, rd_data;
  logic [insn_w-1:0] masked, mask_s, imm_raw, imm;

  decode_if dec ();
  stack_if  stk ();
  cstk_if   cst ();

  decoder    u_dec (.insn(insn), .dec(dec.dec));
  alu        u_alu (.sel(dec.alu_sel), .a(op_a), .b(op_b), .stk0(stk.stk0), .result(alu_res));
  data_stack u_dstk (.clk(clk), .rst_n(rst_n), .s(stk.stk));
  call_stack u_cstk (.clk(clk), .rst_n(rst_n), .c(cst.stk));

  assign ip_next2 = ip + data_w'(2);
  assign masked   = insn & dec.imm_mask;
  assign mask_s   = dec.imm_mask[0] ? dec.imm_mask : dec.imm_mask >> 1;
  assign imm_raw  = dec.imm_mask[0] ? masked : masked >> 1;
  assign imm      = dec.sign ? (imm_raw | ~mask_s) : imm_raw;  // Extend above the field

  always_comb
  begin
    case (dec.src_a)
      src_fp:   op_a = fp;
      src_ip:   op_a = ip;
      src_cstk: op_a = cst.ctop;
      default:  op_a = stk.stk0;
    endcase
    case (dec.src_b)
      src_stk1: op_b = stk.stk1;
      src_isr:  op_b = isr;
      default:  op_b = imm;
    endcase
  end

  assign rd_data     = dec.byt ? {8'h00, dmem_rdata[7:0]} : dmem_rdata;
  assign stk.push    = dec.push;
  assign stk.pop     = dec.pop;
  assign stk.load    = dec.load_stk;
  assign stk.wr_stk1 = dec.wr_stk1;
  assign stk.din     = dec.rd_mem ? rd_data : alu_res;
  assign cst.cpush   = dec.cpush;
  assign cst.cpop    = dec.cpop;
  assign cst.cdin    = (dec.src_a == src_fp) ? fp : ip_next2;  // CPUSH FP saves the frame

  assign imem_addr  = ip;
  assign dmem_addr  = alu_res;
  assign dmem_wdata = (dec.src_b == src_stk1) ? stk.stk1 : stk.stk0;
  assign dmem_we    = rst_n && dec.wr_mem;
  assign dmem_re    = rst_n && dec.rd_mem;
  assign dmem_byte  = dec.byt && (dec.rd_mem || dec.wr_mem);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ip  <= reset_ip;
      fp  <= '0;
      isr <= '0;
    end
    else
    begin
      ip <= dec.load_ip ? alu_res : ip_next2;
      if (dec.load_fp)
        fp <= alu_res;
      if (dec.load_isr)
        isr <= alu_res;
    end
  end

  a_mem_excl: assert property (@(posedge clk) !(dmem_we && dmem_re))
    else $error("dmem read and write in one cycle");

endmodule

//--- tb_stack_cpu.sv
`timescale 1ns/100ps

module tb_stack_cpu;
  import cpu_isa_pkg::*;

  localparam int max_cycles = 2000;  // Six programs under 40 insns plus resets and margin

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic [15:0] imem_addr, insn, dmem_addr, dmem_wdata, dmem_rdata;
  logic        dmem_we, dmem_re, dmem_byte;

  logic [15:0] imem [256];
  logic [7:0]  dmem [1024];
  logic [15:0] wr_log [$];   // Store addresses in execution order
  logic [15:0] rd_log [$];   // Load addresses in execution order
  logic [31:0] rng = 32'd90;
  string       test_name = "";
  int          wp, errors = 0, cycles = 0;

  stack_cpu UUT (.clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .insn(insn),
                 .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
                 .dmem_re(dmem_re), .dmem_byte(dmem_byte), .dmem_rdata(dmem_rdata));

  always #20 clk = ~clk;

  assign insn       = imem[imem_addr[8:1]];
  assign dmem_rdata = {dmem[dmem_addr[9:0] + 10'd1], dmem[dmem_addr[9:0]]};

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles)
    begin
      $display("Timeout: the core never reached its halt address in %0d cycles", max_cycles);
      $display("Test failed");
      $finish;
    end
  end

  // Data memory model and byte strobe check
  always @(posedge clk)
  begin
    if (rst_n && (dmem_we || dmem_re))
    begin
      assert (dmem_byte === (insn[15:13] == 3'b001))
      else
      begin
        $display("ERROR %s dmem_byte expected %b actual %b", test_name,
                 insn[15:13] == 3'b001, dmem_byte);
        errors++;
      end
    end
    if (rst_n && dmem_re)
      rd_log.push_back(dmem_addr);
    if (rst_n && dmem_we)
    begin
      dmem[dmem_addr[9:0]] <= dmem_wdata[7:0];
      if (!dmem_byte)
        dmem[dmem_addr[9:0] + 10'd1] <= dmem_wdata[15:8];
      wr_log.push_back(dmem_addr);
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [7:0] fill_byte(input logic [9:0] a);
    return a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]} ^ 8'h5a;
  endfunction

  function automatic logic [15:0] word_at(input logic [15:0] a);
    return {dmem[a[9:0] + 10'd1], dmem[a[9:0]]};
  endfunction

  function automatic logic [15:0] fill_word(input logic [15:0] a);
    return {fill_byte(a[9:0] + 10'd1), fill_byte(a[9:0])};
  endfunction

  // Instruction encoders
  function automatic logic [15:0] lit(input logic [15:0] v);
    return 16'h8000 | {1'b0, v[14:0]};
  endfunction
  function automatic logic [15:0] jump(input logic [10:0] off);
    return {4'h0, off, 1'b0};
  endfunction
  function automatic logic [15:0] call_to(input logic [10:0] off);
    return {4'h0, off, 1'b1};
  endfunction
  function automatic logic [15:0] jz(input logic [10:0] off);
    return {4'h1, off, 1'b0};
  endfunction
  function automatic logic [15:0] jnz(input logic [10:0] off);
    return {4'h1, off, 1'b1};
  endfunction
  function automatic logic [15:0] load_word(input logic [8:0] a);
    return {6'b010000, a, 1'b0};
  endfunction
  function automatic logic [15:0] store_word(input logic [8:0] a);
    return {6'b010000, a, 1'b1};
  endfunction
  function automatic logic [15:0] store_frame(input logic [8:0] off);
    return {6'b010001, off, 1'b1};  // fp plus offset
  endfunction
  function automatic logic [15:0] load_byte(input logic [9:0] a);
    return {6'b001000, a};
  endfunction
  function automatic logic [15:0] store_byte(input logic [9:0] a);
    return {6'b001100, a};
  endfunction
  function automatic logic [15:0] add_fp(input logic [9:0] k);
    return {6'b011001, k};
  endfunction
  function automatic logic [15:0] alu_op(input alu_sel_t sel, input logic pop);
    return {9'b0111_0000_0, pop, sel};
  endfunction

  task automatic emit(input logic [15:0] w);
    imem[wp] = w;
    wp++;
  endtask

  function automatic logic [15:0] here();
    return 16'(2 * wp);
  endfunction

  function automatic logic [15:0] rand15();
    rng = xorshift(rng);
    return {1'b0, rng[14:0]};
  endfunction

  task automatic hold_reset(input string name);
    test_name = name;
    for (int i = 0; i < 256; i++)
      imem[i] = 16'h8000 | 16'(i);
    for (int i = 0; i < 1024; i++)
      dmem[i] = fill_byte(10'(i));
    wr_log.delete();
    rd_log.delete();
    wp = 0;
    @(posedge clk);
    rst_n <= 1'b0;
    @(posedge clk);
  endtask

  task automatic release_and_run(input logic [15:0] halt);
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    do
      @(posedge clk);
    while (imem_addr !== halt);
  endtask

  task automatic expect_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (exp === act)
    else
    begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic push_alu();
    alu_sel_t    ops [4];
    logic [15:0] x, y, halt;
    logic [15:0] exp [4];
    ops = '{alu_add, alu_sub, alu_and, alu_xor};
    hold_reset("push_alu");
    x = rand15();
    y = rand15();
    exp = '{y + x, y - x, y & x, y ^ x};  // A is the top and B the entry below
    for (int i = 0; i < 4; i++)
    begin
      emit(lit(x));
      emit(lit(y));
      emit(alu_op(ops[i], 1'b1));
      emit(store_word(9'(16'h80 + 2 * i)));
    end
    emit(lit(x));
    emit(lit(y));
    emit(alu_op(alu_lt, 1'b0));  // Compare result lands in the second entry
    emit(store_word(9'h88));
    emit(store_word(9'h8a));
    halt = here();
    emit(jump(0));
    release_and_run(halt);
    for (int i = 0; i < 4; i++)
      expect_eq("push_alu", exp[i], word_at(16'(16'h80 + 2 * i)));
    expect_eq("push_alu", y, word_at(16'h88));
    expect_eq("push_alu", {15'b0, $signed(y) < $signed(x)}, word_at(16'h8a));
  endtask

  task automatic load_store();
    logic [15:0] w, b, halt;
    hold_reset("load_store");
    w = rand15();
    b = rand15();
    emit(lit(w));
    emit(store_word(9'h90));
    emit(lit(b));
    emit(store_byte(10'h95));
    emit(load_word(9'h90));
    emit(store_word(9'ha0));
    emit(load_byte(10'h95));
    emit(store_word(9'ha2));
    emit(load_byte(10'h91));  // High byte of w
    emit(store_word(9'ha4));
    halt = here();
    emit(jump(0));
    release_and_run(halt);
    expect_eq("load_store", w, word_at(16'h90));
    expect_eq("load_store", {fill_byte(10'h96), b[7:0]}, word_at(16'h95));
    expect_eq("load_store", {8'h00, fill_byte(10'h94)}, {8'h00, dmem[10'h94]});
    expect_eq("load_store", w, word_at(16'ha0));
    expect_eq("load_store", {8'h00, b[7:0]}, word_at(16'ha2));
    expect_eq("load_store", {8'h00, w[15:8]}, word_at(16'ha4));
    expect_eq("load_store", 16'd3, 16'(rd_log.size()));
    if (rd_log.size() == 3)
    begin
      expect_eq("load_store", 16'h90, rd_log[0]);
      expect_eq("load_store", 16'h95, rd_log[1]);
      expect_eq("load_store", 16'h91, rd_log[2]);
    end
  endtask

  task automatic branch();
    logic [15:0] m [5];
    logic [15:0] halt;
    hold_reset("branch");
    for (int i = 0; i < 5; i++)
      m[i] = rand15();
    emit(lit(16'h0));
    emit(jz(11'd6));   // Taken
    emit(lit(m[0]));
    emit(store_word(9'hb0));
    emit(lit(16'h5));
    emit(jz(11'd6));   // Falls through
    emit(lit(m[1]));
    emit(store_word(9'hb2));
    emit(lit(16'h7));
    emit(jnz(11'd6));  // Taken
    emit(lit(m[2]));
    emit(store_word(9'hb4));
    emit(lit(16'h0));
    emit(jnz(11'd6));  // Falls through
    emit(lit(m[3]));
    emit(store_word(9'hb6));
    emit(lit(m[4]));
    emit(store_word(9'hb8));
    halt = here();
    emit(jump(0));
    release_and_run(halt);
    expect_eq("branch", fill_word(16'hb0), word_at(16'hb0));
    expect_eq("branch", m[1], word_at(16'hb2));
    expect_eq("branch", fill_word(16'hb4), word_at(16'hb4));
    expect_eq("branch", m[3], word_at(16'hb6));
    expect_eq("branch", m[4], word_at(16'hb8));
  endtask

  task automatic check_order(input string name, input logic [15:0] first,
                             input logic [15:0] second);
    expect_eq(name, 16'd2, 16'(wr_log.size()));
    expect_eq(name, 16'd0, 16'(rd_log.size()));
    if (wr_log.size() == 2)
    begin
      expect_eq(name, first, wr_log[0]);
      expect_eq(name, second, wr_log[1]);
    end
    assert (UUT.u_cstk.ptr == '0)
    else
    begin
      $display("The call stack is not empty at the end of %s", name);
      errors++;
    end
  endtask

  task automatic call_ret();
    logic [15:0] m1, m2;
    hold_reset("call_ret");
    m1 = rand15();
    m2 = rand15();
    emit(call_to(11'd8));
    emit(lit(m2));
    emit(store_word(9'hc2));
    emit(jump(0));        // Halt at 6
    emit(lit(m1));        // Subroutine
    emit(store_word(9'hc0));
    emit(16'h7800);       // RET
    release_and_run(16'd6);
    expect_eq("call_ret", m1, word_at(16'hc0));
    expect_eq("call_ret", m2, word_at(16'hc2));
    check_order("call_ret", 16'hc0, 16'hc2);
  endtask

  task automatic frame();
    logic [15:0] v1, v2, v3, halt;
    hold_reset("frame");
    v1 = rand15();
    v2 = rand15();
    v3 = rand15();
    emit(add_fp(10'h100));
    emit(lit(v1));
    emit(store_frame(9'd4));
    emit(16'h7803);       // CPUSH FP
    emit(add_fp(10'h020));
    emit(lit(v2));
    emit(store_frame(9'd4));
    emit(16'h7802);       // CPOP FP
    emit(lit(v3));
    emit(store_frame(9'd6));
    halt = here();
    emit(jump(0));
    release_and_run(halt);
    expect_eq("frame", v1, word_at(16'h104));
    expect_eq("frame", v2, word_at(16'h124));
    expect_eq("frame", v3, word_at(16'h106));
  endtask

  task automatic interrupt();
    logic [15:0] m1, m2;
    hold_reset("interrupt");
    m1 = rand15();
    m2 = rand15();
    emit(lit(16'd12));    // Handler address
    emit(16'h7811);       // Load isr
    emit(16'h7810);       // INT
    emit(lit(m2));
    emit(store_word(9'hd2));
    emit(jump(0));        // Halt at 10
    emit(lit(m1));
    emit(store_word(9'hd0));
    emit(16'h7800);
    release_and_run(16'd10);
    expect_eq("interrupt", m1, word_at(16'hd0));
    expect_eq("interrupt", m2, word_at(16'hd2));
    check_order("interrupt", 16'hd0, 16'hd2);
  endtask

  initial
  begin
    push_alu();
    load_store();
    branch();
    call_ret();
    frame();
    interrupt();
    $display("Checks finished with %0d errors", errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- sources.f
cpu_cfg_pkg.sv
cpu_isa_pkg.sv
cpu_ifs.sv
decoder.sv
alu.sv
data_stack.sv
call_stack.sv
stack_cpu.sv
tb_stack_cpu.sv

//--- run.sh
#!/bin/bash
# Build and run the stack CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_stack_cpu \
  --Mdir obj_dir -o sim_stack_cpu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_stack_cpu > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
